/* sim/hough_input.txt */
# Header: name, hold (1 leaves result in FIFO), expected rho_bin, theta, votes
# Then 16 pixel rows, four per line, one hex digit per column (1 bright, 0 just below)
single_point 0 12 3 1
0000010000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
vertical_x5 1 21 0 16
0000010000000000 0000010000000000 0000010000000000 0000010000000000
0000010000000000 0000010000000000 0000010000000000 0000010000000000
0000010000000000 0000010000000000 0000010000000000 0000010000000000
0000010000000000 0000010000000000 0000010000000000 0000010000000000
horizontal_y9 0 25 2 16
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 1111111111111111 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
anti_diagonal 0 26 1 16
0000000000000001 0000000000000010 0000000000000100 0000000000001000
0000000000010000 0000000000100000 0000000001000000 0000000010000000
0000000100000000 0000001000000000 0000010000000000 0000100000000000
0001000000000000 0010000000000000 0100000000000000 1000000000000000
below_threshold 0 0 0 0
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
dense 0 16 3 31
1111111111111111 1111111111111111 1111111111111111 1111111111111111
1111111111111111 1111111111111111 1111111111111111 1111111111111111
1111111111111111 1111111111111111 1111111111111111 1111111111111111
1111111111111111 1111111111111111 1111111111111111 1111111111111111
single_point_after_dense 0 12 3 1
0000010000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000

/* hough_top.f */
+incdir+include
source/hough_pkg.sv
source/fifo.sv
source/edge_marker.sv
source/edge_scanner.sv
source/theta_lane.sv
source/peak_picker.sv
source/hough_top.sv
sim/hough_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the Hough testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module hough_tb \
    -f hough_top.f -o hough_sim \
    && ./obj_dir/hough_sim | tee sim.log
grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* sim/hough_tb.sv */
// Hough subsystem testbench
`timescale 1ns/1ns
`include "hough_defines.svh"

module hough_tb;

    localparam int WAIT_LIMIT = 2000;

    logic        clock;
    logic        reset;
    logic        image_wr_en;
    logic [23:0] image_din;
    logic        image_full;
    logic        result_rd_en;
    logic        result_empty;
    logic [5:0]  result_rho_bin;
    logic [1:0]  result_theta;
    logic [8:0]  result_votes;

    int          fd;
    int          error_count;
    int          timeout_count;
    int          check_count;
    logic [63:0] frame_rows [`IMAGE_HEIGHT];
    string       test_name;
    int          test_hold;
    int          exp_rho;
    int          exp_theta;
    int          exp_votes;
    // Results still owed by the DUT in arrival order
    string       pend_name [$];
    int          pend_rho [$];
    int          pend_theta [$];
    int          pend_votes [$];

    hough_top uut (
        .clock(clock),
        .reset(reset),
        .image_wr_en(image_wr_en),
        .image_din(image_din),
        .image_full(image_full),
        .result_rd_en(result_rd_en),
        .result_empty(result_empty),
        .result_rho_bin(result_rho_bin),
        .result_theta(result_theta),
        .result_votes(result_votes)
    );

    always #2 clock = ~clock;

    // Skips blank lines and comment lines
    task automatic next_data_line(output string line, output bit found);
        bit done;
        found = 1'b0;
        done  = 1'b0;
        while (!done) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else if (line.len() > 1 && line.getc(0) != "#") begin
                found = 1'b1;
                done  = 1'b1;
            end
        end
    endtask

    // Header line, then four lines of four pixel rows
    task automatic read_test(output bit found);
        string       line;
        int          n;
        int          row;
        logic [63:0] r0;
        logic [63:0] r1;
        logic [63:0] r2;
        logic [63:0] r3;
        next_data_line(line, found);
        if (found) begin
            n = $sscanf(line, "%s %d %d %d %d", test_name, test_hold,
                        exp_rho, exp_theta, exp_votes);
            if (n != 5) begin
                $display("Malformed test header: %s", line);
                error_count++;
                found = 1'b0;
            end
        end
        row = 0;
        while (found && row < `IMAGE_HEIGHT) begin
            next_data_line(line, found);
            if (!found) begin
                $display("Pixel rows missing in test %s", test_name);
                error_count++;
            end else begin
                n = $sscanf(line, "%h %h %h %h", r0, r1, r2, r3);
                if (n == 4) begin
                    frame_rows[row]     = r0;
                    frame_rows[row + 1] = r1;
                    frame_rows[row + 2] = r2;
                    frame_rows[row + 3] = r3;
                    row += 4;
                end else begin
                    $display("Malformed pixel rows in test %s", test_name);
                    error_count++;
                    found = 1'b0;
                end
            end
        end
    endtask

    // r + 2g + b lands on 508..511 for dark codes and on 512 for bright ones
    function automatic logic [23:0] pixel_rgb(input logic [3:0] code, input int x, input int y);
        logic [1:0] pick;
        pick = 2'(x + y);
        if (code != 4'd0) begin
            pixel_rgb = pick[0] ? {8'd200, 8'd100, 8'd112} : {8'd128, 8'd128, 8'd128};
        end else begin
            case (pick)
                2'd0:    pixel_rgb = {8'd127, 8'd127, 8'd127};
                2'd1:    pixel_rgb = {8'd128, 8'd127, 8'd127};
                2'd2:    pixel_rgb = {8'd129, 8'd127, 8'd128};
                default: pixel_rgb = {8'd131, 8'd126, 8'd128};
            endcase
        end
    endfunction

    task automatic send_pixel(input logic [23:0] rgb, output bit ok);
        int waited;
        int gap;
        waited = 0;
        while (image_full && waited < WAIT_LIMIT) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (image_full) begin
            $display("Timeout waiting for image_full to clear in test %s", test_name);
            timeout_count++;
            ok = 1'b0;
        end else begin
            image_wr_en = 1'b1;
            image_din   = rgb;
            @(posedge clock);
            #1;
            image_wr_en = 1'b0;
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clock);
                #1;
            end
            ok = 1'b1;
        end
    endtask

    // Raster order with the leftmost hex digit as column 0
    task automatic send_frame(output bit ok);
        logic [3:0] code;
        ok = 1'b1;
        for (int y = 0; y < `IMAGE_HEIGHT; y++) begin
            for (int x = 0; x < `IMAGE_WIDTH; x++) begin
                code = frame_rows[y][4 * (`IMAGE_WIDTH - 1 - x) +: 4];
                if (ok) begin
                    send_pixel(pixel_rgb(code, x, y), ok);
                end
            end
        end
    endtask

    task automatic check_value(input string name, input string field,
                               input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            $display("Fail %s %s: expected %0d, actual %0d", name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic read_result(output bit ok);
        int    waited;
        string name;
        int    rho;
        int    theta;
        int    votes;
        name   = pend_name.pop_front();
        rho    = pend_rho.pop_front();
        theta  = pend_theta.pop_front();
        votes  = pend_votes.pop_front();
        waited = 0;
        while (result_empty && waited < WAIT_LIMIT) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (result_empty) begin
            $display("Timeout waiting for a result in test %s", name);
            timeout_count++;
            ok = 1'b0;
        end else begin
            check_value(name, "rho_bin", rho, int'(result_rho_bin));
            check_value(name, "theta", theta, int'(result_theta));
            check_value(name, "votes", votes, int'(result_votes));
            result_rd_en = 1'b1;
            @(posedge clock);
            #1;
            result_rd_en = 1'b0;
            ok = 1'b1;
        end
    endtask

    task automatic drain_results(output bit ok);
        ok = 1'b1;
        while (ok && pend_name.size() > 0) begin
            read_result(ok);
        end
    endtask

    initial begin
        bit found;
        bit ok;
        bit running;
        clock         = 1'b0;
        reset         = 1'b1;
        image_wr_en   = 1'b0;
        image_din     = '0;
        result_rd_en  = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        check_count   = 0;
        void'($urandom(95602));
        fd = $fopen("sim/hough_input.txt", "r");
        repeat (4) begin
            @(posedge clock);
        end
        #1;
        reset = 1'b0;
        running = (fd != 0);
        if (fd == 0) begin
            $display("Cannot open sim/hough_input.txt");
            error_count++;
        end
        while (running) begin
            read_test(found);
            if (!found) begin
                running = 1'b0;
            end else begin
                pend_name.push_back(test_name);
                pend_rho.push_back(exp_rho);
                pend_theta.push_back(exp_theta);
                pend_votes.push_back(exp_votes);
                send_frame(ok);
                // A held result stays in the result FIFO behind later frames
                if (ok && test_hold == 0) begin
                    drain_results(ok);
                end
                if (!ok) begin
                    running = 1'b0;
                end
            end
        end
        if (timeout_count == 0) begin
            drain_results(ok);
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* source/hough_top.sv */
// Hough lane-line subsystem top
`timescale 1ns/1ns
`include "hough_defines.svh"

module hough_top import hough_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    // Pixel input
    input  logic        image_wr_en,
    input  logic [23:0] image_din,
    output logic        image_full,
    // Line result output
    input  logic        result_rd_en,
    output logic        result_empty,
    output logic [5:0]  result_rho_bin,
    output logic [1:0]  result_theta,
    output logic [8:0]  result_votes
);

    rgb_t       image_dout;
    logic       image_empty;
    logic       image_rd_en;
    logic       frame_free;
    logic       frame_done;
    logic       edge_wr_en;
    logic [7:0] edge_wr_addr;
    logic       edge_wr_bit;
    logic       point_valid;
    logic [3:0] point_x;
    logic [3:0] point_y;
    logic       scan_done;
    logic [5:0] rd_bin;
    logic       rd_clear;
    logic [`THETA_UNROLL-1:0][`VOTE_BITS-1:0] lane_votes;
    logic       result_wr_en;
    logic       result_full;
    line_t      result_din;
    line_t      result_dout;

    assign result_rho_bin = result_dout.rho_bin;
    assign result_theta   = result_dout.theta;
    assign result_votes   = result_dout.votes;

    fifo #(
        .payload_t(rgb_t),
        .FIFO_BUFFER_SIZE(`FIFO_BUFFER_SIZE)
    ) fifo_image_inst (
        .clock(clock),
        .reset(reset),
        .wr_en(image_wr_en),
        .din(image_din),
        .full(image_full),
        .rd_en(image_rd_en),
        .dout(image_dout),
        .empty(image_empty)
    );

    edge_marker edge_marker_inst (
        .clock(clock),
        .reset(reset),
        .frame_free(frame_free),
        .in_rd_en(image_rd_en),
        .in_empty(image_empty),
        .in_dout(image_dout),
        .edge_wr_en(edge_wr_en),
        .edge_wr_addr(edge_wr_addr),
        .edge_wr_bit(edge_wr_bit),
        .frame_done(frame_done)
    );

    edge_scanner edge_scanner_inst (
        .clock(clock),
        .reset(reset),
        .edge_wr_en(edge_wr_en),
        .edge_wr_addr(edge_wr_addr),
        .edge_wr_bit(edge_wr_bit),
        .frame_done(frame_done),
        .point_valid(point_valid),
        .point_x(point_x),
        .point_y(point_y),
        .scan_done(scan_done)
    );

    // All lanes see every edge point in the same cycle
    for (genvar i = 0; i < `THETA_UNROLL; i++) begin : g_lane
        theta_lane #(
            .LANE(i)
        ) theta_lane_inst (
            .clock(clock),
            .reset(reset),
            .point_valid(point_valid),
            .point_x(point_x),
            .point_y(point_y),
            .rd_bin(rd_bin),
            .rd_clear(rd_clear),
            .rd_votes(lane_votes[i])
        );
    end

    peak_picker peak_picker_inst (
        .clock(clock),
        .reset(reset),
        .scan_done(scan_done),
        .rd_bin(rd_bin),
        .rd_clear(rd_clear),
        .lane_votes(lane_votes),
        .result_wr_en(result_wr_en),
        .result_din(result_din),
        .result_full(result_full),
        .frame_free(frame_free)
    );

    fifo #(
        .payload_t(line_t),
        .FIFO_BUFFER_SIZE(`FIFO_BUFFER_SIZE)
    ) fifo_result_inst (
        .clock(clock),
        .reset(reset),
        .wr_en(result_wr_en),
        .din(result_din),
        .full(result_full),
        .rd_en(result_rd_en),
        .dout(result_dout),
        .empty(result_empty)
    );

endmodule

/* source/peak_picker.sv */
// Accumulator peak search
`timescale 1ns/1ns
`include "hough_defines.svh"

module peak_picker import hough_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       scan_done,
    output logic [5:0] rd_bin,
    output logic       rd_clear,
    input  logic [`THETA_UNROLL-1:0][`VOTE_BITS-1:0] lane_votes,
    output logic       result_wr_en,
    output line_t      result_din,
    input  logic       result_full,
    output logic       frame_free
);

    localparam int LANE_BITS = $clog2(`THETA_UNROLL);

    typedef enum logic [1:0] {IDLE, SWEEP, PUSH} state_t;

    state_t                state;
    logic                  clearing;
    logic [5:0]            bin_cnt;
    logic [`VOTE_BITS-1:0] best_votes;
    logic [5:0]            best_bin;
    logic [LANE_BITS-1:0]  best_lane;
    logic [`VOTE_BITS-1:0] cand_votes;
    logic [LANE_BITS-1:0]  cand_lane;

    // Best lane in this bin with the lower lane winning a tie
    always_comb begin
        cand_votes = lane_votes[0];
        cand_lane  = '0;
        for (int i = 1; i < `THETA_UNROLL; i++) begin
            if (lane_votes[i] > cand_votes) begin
                cand_votes = lane_votes[i];
                cand_lane  = LANE_BITS'(i);
            end
        end
    end

    assign rd_bin       = bin_cnt;
    assign rd_clear     = (state == SWEEP);
    assign frame_free   = (state == IDLE);
    assign result_wr_en = (state == PUSH) && !result_full;
    assign result_din   = '{rho_bin: best_bin, theta: best_lane, votes: best_votes};

    always_ff @(posedge clock) begin
        if (state == IDLE) begin
            best_votes <= '0;
            best_bin   <= '0;
            best_lane  <= '0;
        end else if (state == SWEEP && !clearing && cand_votes > best_votes) begin
            // Strictly greater keeps the lower bin on ties
            best_votes <= cand_votes;
            best_bin   <= bin_cnt;
            best_lane  <= cand_lane;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Reset sweeps the lanes once to zero them
            state    <= SWEEP;
            clearing <= 1'b1;
            bin_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    bin_cnt <= '0;
                    if (scan_done) state <= SWEEP;
                end
                SWEEP: begin
                    bin_cnt <= bin_cnt + 1'b1;
                    if (bin_cnt == 6'(`RHO_BINS - 1)) begin
                        state    <= clearing ? IDLE : PUSH;
                        clearing <= 1'b0;
                    end
                end
                PUSH:    if (!result_full) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/theta_lane.sv */
// Single-angle vote lane
`timescale 1ns/1ns
`include "hough_defines.svh"

module theta_lane import hough_pkg::*; #(
    parameter int LANE = 0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  point_valid,
    input  logic [3:0]            point_x,
    input  logic [3:0]            point_y,
    input  logic [5:0]            rd_bin,
    input  logic                  rd_clear,
    output logic [`VOTE_BITS-1:0] rd_votes
);

    localparam int BIN_BITS = $clog2(`RHO_BINS);
    localparam int Q_SHIFT  = 6;
    localparam logic signed [13:0] COS_C  = COS_Q6[LANE];
    localparam logic signed [13:0] SIN_C  = SIN_Q6[LANE];
    localparam logic signed [13:0] OFFSET = 14'(`RHO_OFFSET);

    logic signed [13:0]    x_s;
    logic signed [13:0]    y_s;
    logic signed [13:0]    dot;
    logic signed [13:0]    rho;
    logic signed [13:0]    bin_full;
    logic [`VOTE_BITS-1:0] votes [`RHO_BINS];
    logic                  inc_q;
    logic [BIN_BITS-1:0]   bin_q;

    assign x_s = {10'd0, point_x};
    assign y_s = {10'd0, point_y};
    assign dot = x_s * COS_C + y_s * SIN_C;
    // Arithmetic shift floors negative rho
    assign rho      = dot >>> Q_SHIFT;
    assign bin_full = rho + OFFSET;

    always_ff @(posedge clock) begin
        bin_q <= bin_full[BIN_BITS-1:0];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            inc_q <= 1'b0;
        end else begin
            inc_q <= point_valid;
        end
    end

    // Vote lands one cycle after the point while the picker sweep clears bins
    always_ff @(posedge clock) begin
        if (inc_q) begin
            votes[bin_q] <= votes[bin_q] + 1'b1;
        end
        if (rd_clear) begin
            votes[rd_bin] <= '0;
        end
    end

    assign rd_votes = votes[rd_bin];

    assert property (@(posedge clock) disable iff (reset)
        point_valid |-> (bin_full >= 0) && (bin_full < `RHO_BINS))
        else $error("theta_lane %0d: rho bin out of range", LANE);

endmodule

/* source/edge_scanner.sv */
// Edge frame store and scanner
`timescale 1ns/1ns
`include "hough_defines.svh"

module edge_scanner (
    input  logic       clock,
    input  logic       reset,
    input  logic       edge_wr_en,
    input  logic [7:0] edge_wr_addr,
    input  logic       edge_wr_bit,
    input  logic       frame_done,
    output logic       point_valid,
    output logic [3:0] point_x,
    output logic [3:0] point_y,
    output logic       scan_done
);

    localparam int ADDR_BITS = $clog2(`IMAGE_SIZE);
    localparam int X_BITS    = $clog2(`IMAGE_WIDTH);

    logic [`IMAGE_SIZE-1:0] edge_mem;
    logic [ADDR_BITS-1:0]   scan_addr;
    logic                   scanning;
    logic                   last_point;

    always_ff @(posedge clock) begin
        if (edge_wr_en) begin
            edge_mem[edge_wr_addr] <= edge_wr_bit;
        end
    end

    // Raster address splits into column and row
    always_ff @(posedge clock) begin
        point_x <= scan_addr[X_BITS-1:0];
        point_y <= scan_addr[ADDR_BITS-1:X_BITS];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            scanning    <= 1'b0;
            scan_addr   <= '0;
            point_valid <= 1'b0;
            last_point  <= 1'b0;
            scan_done   <= 1'b0;
        end else begin
            point_valid <= scanning && edge_mem[scan_addr];
            last_point  <= scanning && (scan_addr == '1);
            // One spare cycle lets the lanes commit the last vote
            scan_done   <= last_point;
            if (frame_done) begin
                scanning  <= 1'b1;
                scan_addr <= '0;
            end else if (scanning) begin
                scan_addr <= scan_addr + 1'b1;
                if (scan_addr == '1) begin
                    scanning <= 1'b0;
                end
            end
        end
    end

    // The marker must stay held while a frame is being scanned
    assert property (@(posedge clock) disable iff (reset) edge_wr_en |-> !scanning)
        else $error("edge_scanner: frame written during scan");

endmodule

/* source/edge_marker.sv */
// Gray threshold edge marker
`timescale 1ns/1ns
`include "hough_defines.svh"

module edge_marker import hough_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       frame_free,
    output logic       in_rd_en,
    input  logic       in_empty,
    input  rgb_t       in_dout,
    output logic       edge_wr_en,
    output logic [7:0] edge_wr_addr,
    output logic       edge_wr_bit,
    output logic       frame_done
);

    typedef enum logic [1:0] {RUN, WAIT_BUSY, WAIT_FREE} state_t;

    state_t     state;
    logic [7:0] pix_count;
    logic [9:0] weighted;
    logic       last_pix;

    // r + 2g + b, then divide by four
    assign weighted = {2'b0, in_dout.r} + {1'b0, in_dout.g, 1'b0} + {2'b0, in_dout.b};
    assign in_rd_en = (state == RUN) && frame_free && !in_empty;
    assign last_pix = (pix_count == 8'(`IMAGE_SIZE - 1));

    always_ff @(posedge clock) begin
        edge_wr_addr <= pix_count;
        edge_wr_bit  <= (weighted[9:2] >= 8'(`EDGE_THRESHOLD));
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= RUN;
            pix_count  <= '0;
            edge_wr_en <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            edge_wr_en <= in_rd_en;
            frame_done <= in_rd_en && last_pix;
            if (in_rd_en) begin
                pix_count <= pix_count + 1'b1;
            end
            // Hold until the picker has taken and finished this frame
            case (state)
                RUN:       if (in_rd_en && last_pix) state <= WAIT_BUSY;
                WAIT_BUSY: if (!frame_free) state <= WAIT_FREE;
                WAIT_FREE: if (frame_free) state <= RUN;
                default:   state <= RUN;
            endcase
        end
    end

endmodule

/* source/fifo.sv */
// Synchronous show-ahead FIFO
`timescale 1ns/1ns

module fifo #(
    parameter type payload_t     = logic [7:0],
    parameter int FIFO_BUFFER_SIZE = 16
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    localparam int ADDR_BITS = $clog2(FIFO_BUFFER_SIZE);

    payload_t mem [FIFO_BUFFER_SIZE];
    // Extra top bit tells full from empty
    logic [ADDR_BITS:0] wr_ptr;
    logic [ADDR_BITS:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
                   (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);
    assign dout  = mem[rd_ptr[ADDR_BITS-1:0]];

    always_ff @(posedge clock) begin
        if (wr_en && !full) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= din;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Producer and consumer must honour the flags
    assert property (@(posedge clock) disable iff (reset) wr_en |-> !full)
        else $error("fifo: write while full");
    assert property (@(posedge clock) disable iff (reset) rd_en |-> !empty)
        else $error("fifo: read while empty");

endmodule

/* source/hough_pkg.sv */
// Hough shared types
`include "hough_defines.svh"

package hough_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [5:0]            rho_bin;
        logic [1:0]            theta;
        logic [`VOTE_BITS-1:0] votes;
    } line_t;

    // Q6 fixed point where 64 stands for 1.0
    localparam logic signed [7:0] COS_Q6 [`THETA_UNROLL] = '{8'sd64, 8'sd45, 8'sd0, -8'sd45};
    localparam logic signed [7:0] SIN_Q6 [`THETA_UNROLL] = '{8'sd0, 8'sd45, 8'sd64, 8'sd45};

endpackage

/* include/hough_defines.svh */
// Hough subsystem sizes
`ifndef HOUGH_DEFINES_SVH
`define HOUGH_DEFINES_SVH

// Frame geometry
`define IMAGE_WIDTH      16
`define IMAGE_HEIGHT     16
`define IMAGE_SIZE       256

// Angle lanes at 0, 45, 90 and 135 degrees
`define THETA_UNROLL     4

// Accumulator layout with bin = rho + offset
`define RHO_BINS         64
`define RHO_OFFSET       16
`define VOTE_BITS        9

`define EDGE_THRESHOLD   128
`define FIFO_BUFFER_SIZE 16

`endif
